//--- hdl/snn_conv_pkg.sv
`default_nettype none

package snn_conv_pkg;

    // ====================
    // Layer geometry
    // ====================
    localparam int in_size = 8;
    localparam int padding = 1;
    localparam int kernel_size = 3;
    localparam int kernel_taps = kernel_size * kernel_size;
    // Same size as input since padding is 1 at stride 1
    localparam int out_size = in_size + 2 * padding - kernel_size + 1;
    localparam int out_channels = 4;
    localparam int neuron_count = out_size * out_size;

    // ====================
    // Field types
    // ====================
    typedef logic [2:0] coord_t;
    typedef logic [1:0] chan_t;
    typedef logic [3:0] tap_t;
    typedef logic signed [7:0] weight_t;
    // Q8.8 membrane potential
    typedef logic signed [15:0] vmem_t;
    // Row in upper three bits, column in lower three
    typedef logic [5:0] pos_t;
    typedef logic [7:0] stamp_t;
    // Channel [31:24], row [23:16], column [15:8], timestamp [7:0]
    typedef logic [31:0] spike_word_t;

    // 1.0 in Q8.8
    localparam vmem_t threshold_default = 16'sh0100;

    // ====================
    // FSM encodings
    // ====================
    typedef enum logic [1:0] {
        sc_idle,
        sc_scatter,
        sc_wait_scan
    } scatter_state_t;

    typedef enum logic [1:0] {
        scan_idle,
        scan_check,
        scan_emit
    } scan_state_t;

endpackage

`default_nettype wire

//--- hdl/spike_scatter.sv
`timescale 1ns/100ps
`default_nettype none

module spike_scatter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      spike_in_valid,
    input  snn_conv_pkg::spike_word_t spike_in_data,
    output logic                      spike_in_ready,
    output logic                      acc_en,
    output snn_conv_pkg::tap_t        acc_tap,
    output snn_conv_pkg::pos_t        acc_pos,
    output logic                      scan_start,
    output snn_conv_pkg::stamp_t      stamp,
    input  logic                      scan_done
);
    import snn_conv_pkg::*;

    scatter_state_t state;

    // Captured spike fields
    coord_t in_row;
    coord_t in_col;
    stamp_t in_stamp;

    // Tap counter with its kernel row and column
    tap_t tap;
    logic [1:0] k_row;
    logic [1:0] k_col;

    // Wide enough that a negative target wraps far out of range
    logic [4:0] t_row;
    logic [4:0] t_col;
    logic in_range;
    logic last_tap;
    logic accept;

    assign spike_in_ready = (state == sc_idle);
    assign accept = spike_in_valid && spike_in_ready;

    // ====================
    // Target position
    // ====================
    // Output = input + padding - kernel offset
    assign t_row = 5'(in_row) + 5'(padding) - 5'(k_row);
    assign t_col = 5'(in_col) + 5'(padding) - 5'(k_col);
    assign in_range = (t_row < 5'(out_size)) && (t_col < 5'(out_size));

    assign acc_en = (state == sc_scatter) && in_range;
    assign acc_tap = tap;
    assign acc_pos = {t_row[2:0], t_col[2:0]};

    // Scan starts alongside the ninth tap and sees its update next cycle
    assign last_tap = (tap == tap_t'(kernel_taps - 1));
    assign scan_start = (state == sc_scatter) && last_tap;
    assign stamp = in_stamp;

    // Input channel field ignored as there is one input channel
    always_ff @(posedge clk) begin
        if (accept) begin
            in_row <= spike_in_data[18:16];
            in_col <= spike_in_data[10:8];
            in_stamp <= spike_in_data[7:0];
        end
    end

    // ====================
    // FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= sc_idle;
            tap <= '0;
            k_row <= '0;
            k_col <= '0;
        end else begin
            case (state)
                sc_idle: begin
                    if (accept) begin
                        state <= sc_scatter;
                        tap <= '0;
                        k_row <= '0;
                        k_col <= '0;
                    end
                end
                sc_scatter: begin
                    if (last_tap) begin
                        state <= sc_wait_scan;
                    end else begin
                        tap <= tap + 1'b1;
                        // Columns step fastest within a kernel row
                        if (k_col == 2'(kernel_size - 1)) begin
                            k_col <= '0;
                            k_row <= k_row + 1'b1;
                        end else begin
                            k_col <= k_col + 1'b1;
                        end
                    end
                end
                sc_wait_scan: begin
                    if (scan_done) begin
                        state <= sc_idle;
                    end
                end
                default: state <= sc_idle;
            endcase
        end
    end

    // Accumulation only on the nine kernel taps
    a_acc_in_scatter: assert property (@(posedge clk) disable iff (!rst_n)
        acc_en |-> tap < tap_t'(kernel_taps));

    // Nine taps from acceptance to scan start
    a_accept_to_scan: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> ##9 scan_start);

endmodule

`default_nettype wire

//--- hdl/conv_channel.sv
`timescale 1ns/100ps
`default_nettype none

module conv_channel #(
    parameter int chan_index = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  weight_wr_en,
    input  snn_conv_pkg::chan_t   weight_wr_chan,
    input  snn_conv_pkg::tap_t    weight_wr_tap,
    input  snn_conv_pkg::weight_t weight_wr_data,
    input  logic                  acc_en,
    input  snn_conv_pkg::tap_t    acc_tap,
    input  snn_conv_pkg::pos_t    acc_pos,
    input  snn_conv_pkg::pos_t    scan_pos,
    input  snn_conv_pkg::vmem_t   threshold,
    input  logic                  clear_en,
    input  snn_conv_pkg::chan_t   clear_chan,
    output logic                  over_thresh
);
    import snn_conv_pkg::*;

    // ====================
    // Storage
    // ====================
    weight_t weights [kernel_taps];
    vmem_t vmem [neuron_count];

    logic weight_hit;
    logic clear_hit;

    // One extra bit to catch overflow
    weight_t tap_weight;
    vmem_t cur_vmem;
    logic [16:0] sum;
    vmem_t sat_sum;

    // Writes to taps past eight are dropped
    assign weight_hit = weight_wr_en && (weight_wr_chan == chan_t'(chan_index)) &&
                        (weight_wr_tap < tap_t'(kernel_taps));
    assign clear_hit = clear_en && (clear_chan == chan_t'(chan_index));

    // ====================
    // Saturating add
    // ====================
    assign tap_weight = weights[acc_tap];
    assign cur_vmem = vmem[acc_pos];
    assign sum = {cur_vmem[15], cur_vmem} + {{9{tap_weight[7]}}, tap_weight};

    always_comb begin
        // Top two bits disagree on overflow
        if (sum[16] != sum[15]) begin
            sat_sum = sum[16] ? 16'sh8000 : 16'sh7fff;
        end else begin
            sat_sum = vmem_t'(sum[15:0]);
        end
    end

    // Signed compare against the shared threshold
    assign over_thresh = (vmem[scan_pos] >= threshold);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < kernel_taps; i++) begin
                weights[i] <= '0;
            end
            for (int n = 0; n < neuron_count; n++) begin
                vmem[n] <= '0;
            end
        end else begin
            if (weight_hit) begin
                weights[weight_wr_tap] <= weight_wr_data;
            end
            if (acc_en) begin
                vmem[acc_pos] <= sat_sum;
            end else if (clear_hit) begin
                // Reset on fire
                vmem[scan_pos] <= '0;
            end
        end
    end

    // Scatter and scan phases never overlap
    a_acc_clear_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(acc_en && clear_en));

endmodule

`default_nettype wire

//--- hdl/fire_scan.sv
`timescale 1ns/100ps
`default_nettype none

module fire_scan (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  snn_conv_pkg::vmem_t                   config_threshold,
    input  logic                                  config_valid,
    input  logic                                  scan_start,
    input  snn_conv_pkg::stamp_t                  stamp,
    output logic                                  scan_done,
    input  logic [snn_conv_pkg::out_channels-1:0] over_thresh,
    output snn_conv_pkg::pos_t                    scan_pos,
    output snn_conv_pkg::vmem_t                   threshold,
    output logic                                  clear_en,
    output snn_conv_pkg::chan_t                   clear_chan,
    output logic                                  spike_out_valid,
    output snn_conv_pkg::spike_word_t             spike_out_data,
    input  logic                                  spike_out_ready
);
    import snn_conv_pkg::*;

    scan_state_t state;
    chan_t low_chan;
    chan_t emit_chan;
    logic any_over;
    logic last_pos;

    // Threshold register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            threshold <= threshold_default;
        end else if (config_valid) begin
            threshold <= config_threshold;
        end
    end

    // ====================
    // Channel select
    // ====================
    // Walk down so the lowest set channel wins
    always_comb begin
        low_chan = '0;
        for (int i = out_channels - 1; i >= 0; i--) begin
            if (over_thresh[i]) begin
                low_chan = chan_t'(i);
            end
        end
    end

    assign any_over = |over_thresh;
    assign last_pos = (scan_pos == pos_t'(neuron_count - 1));
    assign scan_done = (state == scan_check) && !any_over && last_pos;

    assign spike_out_valid = (state == scan_emit);
    assign clear_en = spike_out_valid && spike_out_ready;
    assign clear_chan = emit_chan;

    // Output word frozen while emitting
    always_ff @(posedge clk) begin
        if (state == scan_check && any_over) begin
            emit_chan <= low_chan;
            spike_out_data <= {8'(low_chan), 5'b0, scan_pos[5:3], 5'b0, scan_pos[2:0], stamp};
        end
    end

    // ====================
    // FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= scan_idle;
            scan_pos <= '0;
        end else begin
            case (state)
                scan_idle: begin
                    if (scan_start) begin
                        state <= scan_check;
                        scan_pos <= '0;
                    end
                end
                scan_check: begin
                    // Stay on this position until nothing is over
                    if (any_over) begin
                        state <= scan_emit;
                    end else if (last_pos) begin
                        state <= scan_idle;
                    end else begin
                        scan_pos <= scan_pos + 1'b1;
                    end
                end
                scan_emit: begin
                    if (spike_out_ready) begin
                        state <= scan_check;
                    end
                end
                default: state <= scan_idle;
            endcase
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        spike_out_valid && !spike_out_ready |=> spike_out_valid && $stable(spike_out_data));

endmodule

`default_nettype wire

//--- hdl/snn_conv.sv
`timescale 1ns/100ps
`default_nettype none

module snn_conv (
    input  logic                      clk,
    input  logic                      rst_n,
    // Input spike stream
    input  logic                      spike_in_valid,
    input  snn_conv_pkg::spike_word_t spike_in_data,
    output logic                      spike_in_ready,
    // Output spike stream
    output logic                      spike_out_valid,
    output snn_conv_pkg::spike_word_t spike_out_data,
    input  logic                      spike_out_ready,
    // Weight write strobe
    input  logic                      weight_wr_en,
    input  snn_conv_pkg::chan_t       weight_wr_chan,
    input  snn_conv_pkg::tap_t        weight_wr_tap,
    input  snn_conv_pkg::weight_t     weight_wr_data,
    // Threshold write strobe
    input  snn_conv_pkg::vmem_t       config_threshold,
    input  logic                      config_valid,
    output logic                      busy
);
    import snn_conv_pkg::*;

    // Scatter to channels
    logic acc_en;
    tap_t acc_tap;
    pos_t acc_pos;

    // Scatter and scan handoff
    logic scan_start;
    logic scan_done;
    stamp_t stamp;

    // Scan to channels and back
    pos_t scan_pos;
    vmem_t threshold;
    logic clear_en;
    chan_t clear_chan;
    logic [out_channels-1:0] over_thresh;

    assign busy = !spike_in_ready;

    spike_scatter spike_scatter_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .spike_in_valid (spike_in_valid),
        .spike_in_data  (spike_in_data),
        .spike_in_ready (spike_in_ready),
        .acc_en         (acc_en),
        .acc_tap        (acc_tap),
        .acc_pos        (acc_pos),
        .scan_start     (scan_start),
        .stamp          (stamp),
        .scan_done      (scan_done)
    );

    // ====================
    // Output channels
    // ====================
    // All channels take the same tap in parallel
    for (genvar c = 0; c < out_channels; c++) begin : g_chan
        conv_channel #(
            .chan_index (c)
        ) conv_channel_i (
            .clk            (clk),
            .rst_n          (rst_n),
            .weight_wr_en   (weight_wr_en),
            .weight_wr_chan (weight_wr_chan),
            .weight_wr_tap  (weight_wr_tap),
            .weight_wr_data (weight_wr_data),
            .acc_en         (acc_en),
            .acc_tap        (acc_tap),
            .acc_pos        (acc_pos),
            .scan_pos       (scan_pos),
            .threshold      (threshold),
            .clear_en       (clear_en),
            .clear_chan     (clear_chan),
            .over_thresh    (over_thresh[c])
        );
    end

    fire_scan fire_scan_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .config_threshold (config_threshold),
        .config_valid     (config_valid),
        .scan_start       (scan_start),
        .stamp            (stamp),
        .scan_done        (scan_done),
        .over_thresh      (over_thresh),
        .scan_pos         (scan_pos),
        .threshold        (threshold),
        .clear_en         (clear_en),
        .clear_chan       (clear_chan),
        .spike_out_valid  (spike_out_valid),
        .spike_out_data   (spike_out_data),
        .spike_out_ready  (spike_out_ready)
    );

endmodule

`default_nettype wire

//--- tb/snn_conv_model.svh
`ifndef SNN_CONV_MODEL_SVH
`define SNN_CONV_MODEL_SVH

// ====================
// Shadow layer state
// ====================
// Weights and membranes per output channel
int mw [out_channels][kernel_taps] = '{default: 0};
int mv [out_channels][neuron_count] = '{default: 0};
int mthr = threshold_default;

// Expected output words
// Write side filled by the model, read side advances on each handshake
logic [31:0] exp_mem [2048];
int exp_wr = 0;
int exp_rd = 0;

// Add and clamp to the signed 16-bit range
function automatic int sat_add(input int v, input int w);
    int s;
    s = v + w;
    if (s > 32767) begin
        s = 32767;
    end else if (s < -32768) begin
        s = -32768;
    end
    return s;
endfunction

// Kernel taps row-major, target = input + padding - offset
task automatic apply_scatter(input int row, input int col);
    int r;
    int c;
    for (int t = 0; t < kernel_taps; t++) begin
        r = row + padding - t / kernel_size;
        c = col + padding - t % kernel_size;
        if (r >= 0 && r < out_size && c >= 0 && c < out_size) begin
            for (int ch = 0; ch < out_channels; ch++) begin
                mv[ch][r * out_size + c] = sat_add(mv[ch][r * out_size + c], mw[ch][t]);
            end
        end
    end
endtask

// Position-major walk, lowest channel first, reset on fire
task automatic predict_fires(input int ts);
    for (int p = 0; p < neuron_count; p++) begin
        for (int ch = 0; ch < out_channels; ch++) begin
            if (mv[ch][p] >= mthr) begin
                exp_mem[exp_wr] = {8'(ch), 5'd0, 3'(p / out_size), 5'd0, 3'(p % out_size), 8'(ts)};
                exp_wr++;
                mv[ch][p] = 0;
            end
        end
    end
endtask

`endif

//--- tb/snn_conv_tb.sv
`timescale 1ns/100ps
`default_nettype none

module snn_conv_tb;
    import snn_conv_pkg::*;

    logic clk;
    logic rst_n;
    logic spike_in_valid;
    spike_word_t spike_in_data;
    logic spike_in_ready;
    logic spike_out_valid;
    spike_word_t spike_out_data;
    logic spike_out_ready;
    logic weight_wr_en;
    chan_t weight_wr_chan;
    tap_t weight_wr_tap;
    weight_t weight_wr_data;
    vmem_t config_threshold;
    logic config_valid;
    logic busy;

    int errors = 0;
    bit timed_out = 1'b0;
    string test_name = "reset";
    bit rand_ready = 1'b0;
    int stim_seed = 34522;
    int ready_seed = 34522;
    logic out_fire;

    `include "snn_conv_model.svh"

    snn_conv snn_conv_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Output back-pressure, random only in the stall test
    initial begin
        spike_out_ready = 1'b1;
        forever begin
            @(posedge clk);
            if (rand_ready) begin
                spike_out_ready <= 1'($random(ready_seed));
            end else begin
                spike_out_ready <= 1'b1;
            end
        end
    end

    // ====================
    // Checkers
    // ====================
    assign out_fire = spike_out_valid && spike_out_ready;

    always @(posedge clk) begin
        if (out_fire) begin
            exp_rd <= exp_rd + 1;
        end
    end

    a_out_word: assert property (@(posedge clk) disable iff (!rst_n)
        out_fire |-> exp_rd < exp_wr && spike_out_data == exp_mem[exp_rd])
        else begin
            errors++;
            $display("Mismatch %s: expected %h actual %h", test_name,
                     $sampled(exp_mem[exp_rd]), $sampled(spike_out_data));
        end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        spike_out_valid && !spike_out_ready |=> spike_out_valid && $stable(spike_out_data))
        else begin
            errors++;
            $display("Output spike changed or vanished while stalled in %s", test_name);
        end

    a_busy: assert property (@(posedge clk) disable iff (!rst_n) busy == !spike_in_ready)
        else begin
            errors++;
            $display("busy is not the inverse of spike_in_ready in %s", test_name);
        end

    // ====================
    // Stimulus tasks
    // ====================
    task automatic load_weight(input int ch, input int tap, input int w);
        @(posedge clk);
        weight_wr_en <= 1'b1;
        weight_wr_chan <= chan_t'(ch);
        weight_wr_tap <= tap_t'(tap);
        weight_wr_data <= weight_t'(w);
        @(posedge clk);
        weight_wr_en <= 1'b0;
        mw[ch][tap] = w;
    endtask

    task automatic set_threshold(input int thr);
        @(posedge clk);
        config_valid <= 1'b1;
        config_threshold <= vmem_t'(thr);
        @(posedge clk);
        config_valid <= 1'b0;
        mthr = thr;
    endtask

    // Scan is over once ready comes back
    task automatic wait_idle();
        int cnt;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
        end while (!spike_in_ready && cnt < 2000);
        if (!spike_in_ready) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: fire scan never finished in %s", test_name);
        end else begin
            assert (exp_rd == exp_wr) else begin
                errors++;
                $display("Mismatch %s: expected %0d output spikes actual %0d",
                         test_name, exp_wr, exp_rd);
            end
        end
    endtask

    task automatic send_spike(input int row, input int col, input int ts);
        int cnt;
        cnt = 0;
        if (timed_out) begin
            return;
        end
        @(posedge clk);
        spike_in_valid <= 1'b1;
        spike_in_data <= {8'd0, 5'd0, 3'(row), 5'd0, 3'(col), 8'(ts)};
        // Accepted on the first edge that sees ready
        do begin
            @(posedge clk);
            cnt++;
        end while (!spike_in_ready && cnt < 100);
        spike_in_valid <= 1'b0;
        if (!spike_in_ready) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: input spike never accepted in %s", test_name);
            return;
        end
        apply_scatter(row, col);
        predict_fires(ts);
        wait_idle();
    endtask

    task automatic close_report();
        $display("Run complete: %0d errors, %0d output spikes checked", errors, exp_rd);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        int row;
        int col;
        rst_n = 1'b0;
        spike_in_valid = 1'b0;
        spike_in_data = '0;
        weight_wr_en = 1'b0;
        weight_wr_chan = '0;
        weight_wr_tap = '0;
        weight_wr_data = '0;
        config_threshold = '0;
        config_valid = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!spike_out_valid && spike_in_ready && !busy) else begin
            errors++;
            $display("Outputs not idle after reset");
        end

        // Distinct weights, low threshold
        test_name = "centre";
        for (int ch = 0; ch < out_channels; ch++) begin
            for (int t = 0; t < kernel_taps; t++) begin
                load_weight(ch, t, (ch + 1) * 16 + t);
            end
        end
        set_threshold(40);
        send_spike(4, 3, 8'h11);

        test_name = "corner";
        send_spike(0, 0, 8'h22);

        // Only channel 0 builds up, fires on the third spike
        test_name = "accumulate";
        set_threshold(threshold_default);
        for (int ch = 0; ch < out_channels; ch++) begin
            for (int t = 0; t < kernel_taps; t++) begin
                load_weight(ch, t, (ch == 0) ? 90 : 0);
            end
        end
        for (int i = 0; i < 4; i++) begin
            send_spike(2, 5, 8'h30 + i);
        end

        // 127 never lands exactly on 32767, so only clamping fires
        test_name = "saturate";
        set_threshold(32767);
        for (int ch = 0; ch < out_channels; ch++) begin
            for (int t = 0; t < kernel_taps; t++) begin
                load_weight(ch, t, 127);
            end
        end
        for (int i = 0; i < 260; i++) begin
            send_spike(6, 6, i);
        end

        test_name = "backpressure";
        set_threshold(150);
        for (int ch = 0; ch < out_channels; ch++) begin
            for (int t = 0; t < kernel_taps; t++) begin
                load_weight(ch, t, 32 + ($random(stim_seed) & 63));
            end
        end
        rand_ready <= 1'b1;
        for (int i = 0; i < 24; i++) begin
            row = $random(stim_seed) & 7;
            col = $random(stim_seed) & 7;
            send_spike(row, col, 8'h80 + i);
        end
        rand_ready <= 1'b0;
        close_report();
    end

endmodule

`default_nettype wire

//--- snn_conv.f
+incdir+tb
hdl/snn_conv_pkg.sv
hdl/spike_scatter.sv
hdl/conv_channel.sv
hdl/fire_scan.sv
hdl/snn_conv.sv
tb/snn_conv_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run from its log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module snn_conv_tb -f snn_conv.f -o snn_conv_sim > build.log 2>&1 \
    && ./obj_dir/snn_conv_sim > sim.log 2>&1 \
    || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -qx "NO ERRORS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
